// ==== rvseed_axi.f ====
+incdir+logic
logic/rvseed_axi_pkg.sv
logic/axi_channel_fsm.sv
logic/beat_counter.sv
logic/lane_align.sv
logic/axi_sram.sv
logic/rvseed_axi.sv
tests/tb_rvseed_axi.sv

// ==== Makefile ====
# verilator flow for the rvseed_axi memory port

TOP       ?= tb_rvseed_axi
FILELIST  ?= rvseed_axi.f
SIM_DIR   ?= sim_build
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -Wno-fatal -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(SIM_DIR) -o $(TOP)
	$(SIM_DIR)/$(TOP) | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG) && echo "sim: pass" || \
		(echo "sim: fail, see $(LOG)"; exit 1)

clean:
	rm -rf $(SIM_DIR) $(LOG)

// ==== tests/tb_rvseed_axi.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rvseed_axi_cfg.svh"

module tb_rvseed_axi import rvseed_axi_pkg::*; ();

    localparam int PERIOD    = 4;
    localparam int RST_CYC   = 16;
    localparam int REQ_WAIT  = 40;      // cycles allowed per request
    localparam int FILL_B    = 512;     // bytes preset by the fill test
    localparam int SRAM_B    = `SRAM_WORDS * 8;
    localparam int RAND_REQS = 200;
    localparam int MAX_REQS  = FILL_B / 8 + RAND_REQS + 48;

    logic clock, reset, rw_valid_i, rw_ready_o;
    rw_req_e  rw_req_i;
    rw_size_e rw_size_i;
    logic [`AXI_ADDR_WIDTH-1:0] rw_addr_i;
    logic [`RW_DATA_WIDTH-1:0]  rw_w_data_i, data_read_o;
    axi_resp_e rw_resp_o;

    logic [7:0]  ref_mem [SRAM_B];      // reference copy of the sram bytes
    logic [31:0] lcg_state = 32'd94;
    int req_count = 0, pulse_count = 0, checks = 0, errors = 0;
    int tests = 0, failed_tests = 0, err_mark = 0;
    string test_name = "reset";

    rvseed_axi uut (.*);

    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2) clock = ~clock;
    end

    single_pulse: assert property (@(posedge clock) disable iff (reset)
            rw_ready_o |=> !rw_ready_o)
        else begin
            $display("%s: rw_ready_o stayed high for more than one cycle", test_name);
            errors++;
        end

    quiet_before_first: assert property (@(posedge clock) disable iff (reset)
            req_count == 0 |-> !rw_ready_o)
        else begin
            $display("rw_ready_o pulsed before any request was issued");
            errors++;
        end

    always @(negedge clock) begin
        if (!reset && rw_ready_o) pulse_count++;
    end

    function automatic logic [15:0] rand16();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];   // low bits of an lcg cycle too fast
    endfunction

    task automatic check_equal(input string what, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        assert (act === exp)
        else begin
            $display("Fail %s %s: expected %h actual %h", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        err_mark  = errors;
    endtask

    task automatic end_test();
        tests++;
        if (errors == err_mark) begin
            $display("test %s ok", test_name);
        end else begin
            failed_tests++;
            $display("test %s failed with %0d errors", test_name, errors - err_mark);
        end
    endtask

    task automatic request(input rw_req_e kind, input logic [31:0] addr, input rw_size_e size,
                           input logic [63:0] wdata, output logic [63:0] rdata,
                           output axi_resp_e resp);
        int waited;
        @(posedge clock);
        #1;
        rw_valid_i  = 1'b1;
        rw_req_i    = kind;
        rw_addr_i   = addr;
        rw_size_i   = size;
        rw_w_data_i = wdata;
        req_count++;
        waited = 0;
        do begin
            @(posedge clock);
            #1;
            waited++;
        end while (!rw_ready_o && waited < REQ_WAIT);
        if (!rw_ready_o) begin
            $display("%s: request at %h got no rw_ready_o in %0d cycles", test_name, addr,
                     REQ_WAIT);
            errors++;
        end
        rdata = data_read_o;
        resp  = rw_resp_o;
        @(posedge clock);           // core keeps valid up through the ready cycle
        #1;
        rw_valid_i = 1'b0;
    endtask

    // little endian bytes from addr up with zero above the size and past the sram end
    function automatic logic [63:0] expect_read(input logic [31:0] addr, input rw_size_e size);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < (1 << size); i++) begin
            if (addr + i < SRAM_B) begin
                v[8*i +: 8] = ref_mem[addr + i];
            end
        end
        return v;
    endfunction

    // one byte past the sram end makes the whole access a slave error
    function automatic axi_resp_e expect_resp(input logic [31:0] addr, input rw_size_e size);
        return (addr + (1 << size) - 1 < SRAM_B) ? OKAY : SLVERR;
    endfunction

    task automatic write_mem(input logic [31:0] addr, input rw_size_e size,
                             input logic [63:0] data);
        logic [63:0] rd;
        axi_resp_e   resp;
        request(REQ_WRITE, addr, size, data, rd, resp);
        check_equal($sformatf("write %h resp", addr), expect_resp(addr, size), resp);
        for (int i = 0; i < (1 << size); i++) begin
            if (addr + i < SRAM_B) begin
                ref_mem[addr + i] = data[8*i +: 8];
            end
        end
    endtask

    task automatic read_mem(input logic [31:0] addr, input rw_size_e size);
        logic [63:0] rd;
        axi_resp_e   resp;
        request(REQ_READ, addr, size, '0, rd, resp);
        check_equal($sformatf("read %h size %0d", addr, size), expect_read(addr, size), rd);
        check_equal($sformatf("read %h resp", addr), expect_resp(addr, size), resp);
    endtask

    initial begin
        logic [63:0] data;
        logic [31:0] addr;
        logic [15:0] r;
        rw_size_e    size;
        reset       = 1'b1;
        rw_valid_i  = 1'b0;
        rw_req_i    = REQ_READ;
        rw_addr_i   = '0;
        rw_size_i   = SIZE_B;
        rw_w_data_i = '0;
        repeat (RST_CYC) @(posedge clock);
        #1;
        reset = 1'b0;

        start_test("quiet_after_reset");
        repeat (8) begin
            @(posedge clock);
            #1;
            check_equal("rw_ready_o", 64'd0, rw_ready_o);
        end
        end_test();

        start_test("fill");
        for (int a = 0; a < FILL_B; a += 8) begin
            write_mem(a, SIZE_D, {~a, a});   // pattern holds the whole address
        end
        read_mem(32'h0, SIZE_D);
        read_mem(FILL_B - 8, SIZE_D);
        end_test();

        start_test("dword_aligned");
        write_mem(32'h40, SIZE_D, 64'h0123_4567_89ab_cdef);
        read_mem(32'h40, SIZE_D);
        end_test();

        start_test("narrow_sizes");
        write_mem(32'h81, SIZE_B, 64'hffff_ffff_ffff_ff5a);
        write_mem(32'h86, SIZE_B, 64'h1111_2222_3333_44a5);
        write_mem(32'h8a, SIZE_H, 64'hffff_ffff_ffff_beef);
        write_mem(32'h8c, SIZE_H, 64'h7777_6666_5555_1357);
        write_mem(32'h94, SIZE_W, 64'hdddd_eeee_cafe_f00d);
        read_mem(32'h81, SIZE_B);
        read_mem(32'h86, SIZE_B);
        read_mem(32'h8a, SIZE_H);
        read_mem(32'h8c, SIZE_H);
        read_mem(32'h94, SIZE_W);
        read_mem(32'h80, SIZE_D);   // neighbours untouched
        read_mem(32'h88, SIZE_D);
        read_mem(32'h90, SIZE_D);
        end_test();

        start_test("lane_crossing");
        write_mem(32'ha6, SIZE_W, 64'h0102_0304_a1b2_c3d4);
        write_mem(32'hb3, SIZE_D, 64'h8877_6655_4433_2211);
        write_mem(32'hc7, SIZE_H, 64'hffff_ffff_ffff_9abc);
        read_mem(32'ha6, SIZE_W);
        read_mem(32'hb3, SIZE_D);
        read_mem(32'hc7, SIZE_H);
        read_mem(32'ha0, SIZE_D);
        read_mem(32'ha8, SIZE_D);
        read_mem(32'hb8, SIZE_D);
        read_mem(32'hc8, SIZE_D);
        end_test();

        start_test("out_of_range");
        write_mem(SRAM_B, SIZE_D, 64'hdead_beef_0bad_f00d);
        read_mem(SRAM_B, SIZE_D);
        write_mem(32'h8000_0004, SIZE_W, 64'h1234_5678);
        read_mem(32'h8000_0004, SIZE_W);
        write_mem(SRAM_B - 4, SIZE_D, 64'h5566_7788_99aa_bbcc);   // second beat past the end
        read_mem(SRAM_B - 4, SIZE_D);
        read_mem(32'h0, SIZE_D);    // low word index of the stray addresses
        read_mem(FILL_B - 8, SIZE_D);
        end_test();

        start_test("random_mix");
        for (int n = 0; n < RAND_REQS; n++) begin
            r    = rand16();
            size = rw_size_e'(r[14:13]);
            addr = 32'(rand16()) % (FILL_B - (1 << size) + 1);
            data[15:0]  = rand16();
            data[31:16] = rand16();
            data[47:32] = rand16();
            data[63:48] = rand16();
            if (r[15]) begin
                write_mem(addr, size, data);
            end else begin
                read_mem(addr, size);
            end
        end
        end_test();

        start_test("ready_pulses");
        @(posedge clock);
        #1;                         // last pulse counted on the negedge before
        check_equal("pulse count", req_count, pulse_count);
        end_test();

        $display("tests %0d  failed %0d  checks %0d  errors %0d", tests, failed_tests, checks,
                 errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        #(PERIOD * (MAX_REQS * REQ_WAIT + RST_CYC));
        $display("watchdog expired in test %s, the run did not finish in time", test_name);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/rvseed_axi.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rvseed_axi_cfg.svh"

module rvseed_axi import rvseed_axi_pkg::*; (
    input  wire                         clock,
    input  wire                         reset,
    input  wire                         rw_valid_i,
    input  rw_req_e                     rw_req_i,
    input  wire  [`AXI_ADDR_WIDTH-1:0]  rw_addr_i,
    input  rw_size_e                    rw_size_i,
    input  wire  [`RW_DATA_WIDTH-1:0]   rw_w_data_i,
    output logic                        rw_ready_o,
    output logic [`RW_DATA_WIDTH-1:0]   data_read_o,
    output axi_resp_e                   rw_resp_o
);

    logic aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
    logic ar_valid, ar_ready, r_valid, r_ready;
    logic idle, last;
    axi_resp_e b_resp, r_resp;
    logic [7:0] len, beat;
    logic [`AXI_ADDR_WIDTH-1:0]   axi_addr;    // shared by aw and ar
    logic [`AXI_DATA_WIDTH-1:0]   w_data, r_data;
    logic [`AXI_DATA_WIDTH/8-1:0] w_strb;

    wire r_hs    = r_valid & r_ready;
    wire data_hs = (w_valid & w_ready) | r_hs;

    axi_channel_fsm u_fsm (
        .clock, .reset, .rw_valid_i, .rw_req_i, .rw_ready_o, .rw_resp_o,
        .aw_valid_o(aw_valid), .aw_ready_i(aw_ready),
        .w_valid_o(w_valid), .w_ready_i(w_ready),
        .b_valid_i(b_valid), .b_ready_o(b_ready), .b_resp_i(b_resp),
        .ar_valid_o(ar_valid), .ar_ready_i(ar_ready),
        .r_valid_i(r_valid), .r_ready_o(r_ready), .r_resp_i(r_resp),
        .last_beat_i(last), .idle_o(idle)
    );

    beat_counter u_beats (
        .clock, .reset, .clear_i(idle), .beat_i(data_hs), .len_i(len),
        .beat_o(beat), .last_o(last)
    );

    lane_align u_lanes (
        .clock, .reset, .rw_addr_i, .rw_size_i, .rw_w_data_i,
        .beat_i(beat), .r_beat_i(r_hs), .r_data_i(r_data),
        .len_o(len), .axi_addr_o(axi_addr), .w_data_o(w_data), .w_strb_o(w_strb),
        .data_read_o
    );

    // read last not needed, the beat counter tracks the burst end
    axi_sram u_sram (
        .clock, .reset,
        .aw_valid_i(aw_valid), .aw_ready_o(aw_ready), .aw_addr_i(axi_addr), .aw_len_i(len),
        .w_valid_i(w_valid), .w_ready_o(w_ready), .w_data_i(w_data), .w_strb_i(w_strb),
        .w_last_i(last),
        .b_valid_o(b_valid), .b_ready_i(b_ready), .b_resp_o(b_resp),
        .ar_valid_i(ar_valid), .ar_ready_o(ar_ready), .ar_addr_i(axi_addr), .ar_len_i(len),
        .r_valid_o(r_valid), .r_ready_i(r_ready), .r_data_o(r_data), .r_resp_o(r_resp),
        .r_last_o()
    );

endmodule

`default_nettype wire

// ==== logic/axi_sram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rvseed_axi_cfg.svh"

module axi_sram import rvseed_axi_pkg::*; #(
    parameter int WORDS = `SRAM_WORDS
) (
    input  wire                          clock,
    input  wire                          reset,
    input  wire                          aw_valid_i,
    output logic                         aw_ready_o,
    input  wire  [`AXI_ADDR_WIDTH-1:0]   aw_addr_i,
    input  wire  [7:0]                   aw_len_i,
    input  wire                          w_valid_i,
    output logic                         w_ready_o,
    input  wire  [`AXI_DATA_WIDTH-1:0]   w_data_i,
    input  wire  [`AXI_DATA_WIDTH/8-1:0] w_strb_i,
    input  wire                          w_last_i,
    output logic                         b_valid_o,
    input  wire                          b_ready_i,
    output axi_resp_e                    b_resp_o,
    input  wire                          ar_valid_i,
    output logic                         ar_ready_o,
    input  wire  [`AXI_ADDR_WIDTH-1:0]   ar_addr_i,
    input  wire  [7:0]                   ar_len_i,
    output logic                         r_valid_o,
    input  wire                          r_ready_i,
    output logic [`AXI_DATA_WIDTH-1:0]   r_data_o,
    output axi_resp_e                    r_resp_o,
    output logic                         r_last_o
);

    localparam int AW = `AXI_ADDR_WIDTH;
    localparam int IW = $clog2(WORDS);
    localparam logic [AW-1:0] WORD_LIMIT = AW'(WORDS);

    typedef enum logic [1:0] {WS_IDLE, WS_DATA, WS_RESP} wr_state_e;

    logic [`AXI_DATA_WIDTH-1:0] mem [WORDS];

    wr_state_e     wr_state;
    logic [AW-1:0] wr_word;     // word index, not byte address
    logic [7:0]    wr_left;
    logic          wr_err;
    logic [AW-1:0] rd_word;
    logic [7:0]    rd_left;

    wire aw_hs  = aw_valid_i & aw_ready_o;
    wire w_hs   = w_valid_i & w_ready_o;
    wire b_hs   = b_valid_o & b_ready_i;
    wire ar_hs  = ar_valid_i & ar_ready_o;
    wire r_hs   = r_valid_o & r_ready_i;
    wire wr_hit = (wr_word < WORD_LIMIT);

    always_ff @(posedge clock) begin
        if (reset) begin
            wr_state <= WS_IDLE;
        end else begin
            case (wr_state)
                WS_IDLE: if (aw_hs) wr_state <= WS_DATA;
                WS_DATA: if (w_hs && w_last_i) wr_state <= WS_RESP;
                WS_RESP: if (b_hs) wr_state <= WS_IDLE;
                default: wr_state <= WS_IDLE;
            endcase
        end
    end

    // last flag that disagrees with aw len also counts as an error
    always_ff @(posedge clock) begin
        if (aw_hs) begin
            wr_word <= aw_addr_i >> 3;
            wr_left <= aw_len_i;
            wr_err  <= 1'b0;
        end else if (w_hs) begin
            wr_word <= wr_word + 1'b1;   // incr, 8 bytes per beat
            wr_left <= wr_left - 8'd1;
            wr_err  <= wr_err | ~wr_hit | (w_last_i != (wr_left == 8'd0));
        end
    end

    always_ff @(posedge clock) begin
        if (w_hs && wr_hit) begin
            for (int i = 0; i < `AXI_DATA_WIDTH / 8; i++) begin
                if (w_strb_i[i]) mem[wr_word[IW-1:0]][8*i +: 8] <= w_data_i[8*i +: 8];
            end
        end
    end

    assign aw_ready_o = (wr_state == WS_IDLE);
    assign w_ready_o  = (wr_state == WS_DATA);
    assign b_valid_o  = (wr_state == WS_RESP);
    assign b_resp_o   = wr_err ? SLVERR : OKAY;

    // read side, next beat fetched while the current one is taken
    wire           rd_load     = ar_hs | (r_hs & ~r_last_o);
    wire [AW-1:0]  rd_word_nxt = ar_hs ? (ar_addr_i >> 3) : rd_word + 1'b1;
    wire [7:0]     rd_left_nxt = ar_hs ? ar_len_i : rd_left - 8'd1;
    wire           rd_hit      = (rd_word_nxt < WORD_LIMIT);

    always_ff @(posedge clock) begin
        if (reset) begin
            r_valid_o <= 1'b0;
        end else if (ar_hs) begin
            r_valid_o <= 1'b1;
        end else if (r_hs && r_last_o) begin
            r_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (rd_load) begin
            rd_word  <= rd_word_nxt;
            rd_left  <= rd_left_nxt;
            r_data_o <= rd_hit ? mem[rd_word_nxt[IW-1:0]] : '0;
            r_resp_o <= rd_hit ? OKAY : SLVERR;
            r_last_o <= (rd_left_nxt == 8'd0);
        end
    end

    assign ar_ready_o = ~r_valid_o;

endmodule

`default_nettype wire

// ==== logic/lane_align.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rvseed_axi_cfg.svh"

module lane_align import rvseed_axi_pkg::*; (
    input  wire                         clock,
    input  wire                         reset,
    input  wire  [`AXI_ADDR_WIDTH-1:0]  rw_addr_i,
    input  rw_size_e                    rw_size_i,
    input  wire  [`RW_DATA_WIDTH-1:0]   rw_w_data_i,
    input  wire  [7:0]                  beat_i,
    input  wire                         r_beat_i,
    input  wire  [`AXI_DATA_WIDTH-1:0]  r_data_i,
    output logic [7:0]                  len_o,
    output logic [`AXI_ADDR_WIDTH-1:0]  axi_addr_o,
    output logic [`AXI_DATA_WIDTH-1:0]  w_data_o,
    output logic [`AXI_DATA_WIDTH/8-1:0] w_strb_o,
    output logic [`RW_DATA_WIDTH-1:0]   data_read_o
);

    localparam int DW = `AXI_DATA_WIDTH;
    localparam int SW = `AXI_DATA_WIDTH / 8;

    logic [SW-1:0]   size_strb;
    logic [2:0]      size_last;      // last byte index within the access
    logic [2*SW-1:0] strb_wide;
    logic [2*DW-1:0] mask_wide;
    logic [2*DW-1:0] w_wide;
    logic [DW-1:0]   lane_mask;
    logic [2*DW-1:0] r_wide;
    logic [DW-1:0]   r_lane;

    wire [2:0] offset   = rw_addr_i[2:0];
    wire [5:0] bit_off  = {offset, 3'b000};
    wire [3:0] lane_end = {1'b0, offset} + {1'b0, size_last};
    wire       hi_beat  = (beat_i != 8'd0);

    always_comb begin
        case (rw_size_i)
            SIZE_B: begin
                size_strb = 8'h01;
                size_last = 3'd0;
            end
            SIZE_H: begin
                size_strb = 8'h03;
                size_last = 3'd1;
            end
            SIZE_W: begin
                size_strb = 8'h0f;
                size_last = 3'd3;
            end
            default: begin
                size_strb = 8'hff;
                size_last = 3'd7;
            end
        endcase
    end

    // two lanes side by side, upper one is beat 1
    assign strb_wide = {{SW{1'b0}}, size_strb} << offset;

    always_comb begin
        for (int i = 0; i < 2 * SW; i++) begin
            mask_wide[8*i +: 8] = {8{strb_wide[i]}};
        end
    end

    assign len_o      = {7'd0, lane_end[3]};   // crossing takes a second beat
    assign axi_addr_o = {rw_addr_i[`AXI_ADDR_WIDTH-1:3], 3'b000};

    assign w_wide   = {{DW{1'b0}}, rw_w_data_i} << bit_off;
    assign w_data_o = hi_beat ? w_wide[2*DW-1:DW] : w_wide[DW-1:0];
    assign w_strb_o = hi_beat ? strb_wide[2*SW-1:SW] : strb_wide[SW-1:0];

    // read lane placed back in its lane pair, then shifted down
    assign lane_mask = hi_beat ? mask_wide[2*DW-1:DW] : mask_wide[DW-1:0];
    assign r_wide    = hi_beat ? {r_data_i & lane_mask, {DW{1'b0}}}
                               : {{DW{1'b0}}, r_data_i & lane_mask};
    assign r_lane    = DW'(r_wide >> bit_off);

    always_ff @(posedge clock) begin
        if (reset) begin
            data_read_o <= '0;
        end else if (r_beat_i) begin
            data_read_o <= hi_beat ? (data_read_o | r_lane) : r_lane;
        end
    end

endmodule

`default_nettype wire

// ==== logic/beat_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module beat_counter (
    input  wire        clock,
    input  wire        reset,
    input  wire        clear_i,
    input  wire        beat_i,
    input  wire  [7:0] len_i,
    output logic [7:0] beat_o,
    output logic       last_o
);

    logic [7:0] count;

    // holds at len so a stray beat cannot run past the burst
    always_ff @(posedge clock) begin
        if (reset || clear_i) begin
            count <= 8'd0;
        end else if (beat_i && count != len_i) begin
            count <= count + 8'd1;
        end
    end

    assign beat_o = count;
    assign last_o = (count == len_i);   // axi len is beats minus one

endmodule

`default_nettype wire

// ==== logic/axi_channel_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_channel_fsm import rvseed_axi_pkg::*; (
    input  wire       clock,
    input  wire       reset,
    input  wire       rw_valid_i,
    input  rw_req_e   rw_req_i,
    output logic      rw_ready_o,
    output axi_resp_e rw_resp_o,
    output logic      aw_valid_o,
    input  wire       aw_ready_i,
    output logic      w_valid_o,
    input  wire       w_ready_i,
    input  wire       b_valid_i,
    output logic      b_ready_o,
    input  axi_resp_e b_resp_i,
    output logic      ar_valid_o,
    input  wire       ar_ready_i,
    input  wire       r_valid_i,
    output logic      r_ready_o,
    input  axi_resp_e r_resp_i,
    input  wire       last_beat_i,
    output logic      idle_o
);

    typedef enum logic [1:0] {W_IDLE, W_ADDR, W_DATA, W_RESP} w_state_e;
    typedef enum logic [1:0] {R_IDLE, R_ADDR, R_DATA} r_state_e;

    w_state_e  w_state;
    r_state_e  r_state;
    axi_resp_e r_worst;     // worst read beat so far

    function automatic axi_resp_e worse(axi_resp_e a, axi_resp_e b);
        return (a > b) ? a : b;
    endfunction

    wire aw_hs  = aw_valid_o & aw_ready_i;
    wire w_hs   = w_valid_o & w_ready_i;
    wire b_hs   = b_valid_i & b_ready_o;
    wire ar_hs  = ar_valid_o & ar_ready_i;
    wire r_hs   = r_valid_i & r_ready_o;
    wire r_done = r_hs & last_beat_i;

    // the ready pulse cycle still sees the old request, so skip it
    wire start = rw_valid_i & ~rw_ready_o & idle_o;

    always_ff @(posedge clock) begin
        if (reset) begin
            w_state <= W_IDLE;
        end else begin
            case (w_state)
                W_IDLE: if (start && rw_req_i == REQ_WRITE) w_state <= W_ADDR;
                W_ADDR: if (aw_hs) w_state <= W_DATA;
                W_DATA: if (w_hs && last_beat_i) w_state <= W_RESP;
                W_RESP: if (b_hs) w_state <= W_IDLE;
                default: w_state <= W_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            r_state <= R_IDLE;
        end else begin
            case (r_state)
                R_IDLE: if (start && rw_req_i == REQ_READ) r_state <= R_ADDR;
                R_ADDR: if (ar_hs) r_state <= R_DATA;
                R_DATA: if (r_done) r_state <= R_IDLE;
                default: r_state <= R_IDLE;
            endcase
        end
    end

    // completion pulse and response capture
    always_ff @(posedge clock) begin
        if (reset) begin
            rw_ready_o <= 1'b0;
            rw_resp_o  <= OKAY;
            r_worst    <= OKAY;
        end else begin
            rw_ready_o <= b_hs | r_done;
            if (b_hs) begin
                rw_resp_o <= b_resp_i;
            end else if (r_done) begin
                rw_resp_o <= worse(r_worst, r_resp_i);
            end
            if (ar_hs) begin
                r_worst <= OKAY;
            end else if (r_hs) begin
                r_worst <= worse(r_worst, r_resp_i);
            end
        end
    end

    assign aw_valid_o = (w_state == W_ADDR);
    assign w_valid_o  = (w_state == W_DATA);
    assign b_ready_o  = (w_state == W_RESP);
    assign ar_valid_o = (r_state == R_ADDR);
    assign r_ready_o  = (r_state == R_DATA);
    assign idle_o     = (w_state == W_IDLE) && (r_state == R_IDLE);

endmodule

`default_nettype wire

// ==== logic/rvseed_axi_pkg.sv ====
`default_nettype none

package rvseed_axi_pkg;

    typedef enum logic {
        REQ_READ  = 1'b0,
        REQ_WRITE = 1'b1
    } rw_req_e;

    // bytes per access = 1 << size
    typedef enum logic [1:0] {
        SIZE_B = 2'd0,
        SIZE_H = 2'd1,
        SIZE_W = 2'd2,
        SIZE_D = 2'd3
    } rw_size_e;

    typedef enum logic [1:0] {
        FIXED = 2'd0,
        INCR  = 2'd1,
        WRAP  = 2'd2     // 2'd3 reserved
    } axi_burst_e;

    // ordered so a larger code is a worse response
    typedef enum logic [1:0] {
        OKAY   = 2'd0,
        EXOKAY = 2'd1,
        SLVERR = 2'd2,
        DECERR = 2'd3
    } axi_resp_e;

endpackage

`default_nettype wire

// ==== logic/rvseed_axi_cfg.svh ====
`ifndef RVSEED_AXI_CFG_SVH
`define RVSEED_AXI_CFG_SVH

// request side, one double word per access
`define RW_DATA_WIDTH 64

// axi master and sram bus
`define AXI_DATA_WIDTH 64
`define AXI_ADDR_WIDTH 32

// sram depth in bus words
`define SRAM_WORDS 512

`endif
